// ==== forth_spram_consts.svh ====
// address and data widths of the 32K x 32 single-port data memory
// bank count and row count of the 16K x 16 bank array
`ifndef FORTH_SPRAM_CONSTS_SVH
`define FORTH_SPRAM_CONSTS_SVH

// byte address, 128K bytes
`define SPRAM_BYTE_AW 17
// word address, 32K words
`define SPRAM_WORD_AW 15
// address inside one 16K bank
`define SPRAM_BANK_AW 14

// one bank holds half a word
`define SPRAM_HALF_W 16
`define SPRAM_WORD_W 32

// rows picked by word address bit 14
`define SPRAM_NROWS 2
// two halves per row
`define SPRAM_NBANKS 4

`endif // FORTH_SPRAM_CONSTS_SVH

// ==== spram_pkg.sv ====
// shared types of the data memory
// words, bank half-words, lane and nibble masks, access mode
`default_nettype none

`include "forth_spram_consts.svh"

package spram_pkg;

    // full data word as seen by the core
    typedef logic [`SPRAM_WORD_W-1:0] word_t;

    // one bank word, upper or lower half
    typedef logic [`SPRAM_HALF_W-1:0] half_t;

    typedef logic [3:0] lane_mask_t; // bit i enables byte i
    typedef logic [3:0] nib_mask_t;  // bit k enables bits 4k+3..4k of a bank

    // word access uses bmsk, byte access uses addr[1:0]
    typedef enum logic {
        acc_word = 1'b0,
        acc_byte = 1'b1
    } access_mode_e;

endpackage

`default_nettype wire

// ==== spram_bank.sv ====
// behavioural 16K x 16 single-port bank with nibble write mask
// stands in for a hard SPRAM macro, read data is registered
`timescale 1ns/1ns
`default_nettype none

`include "forth_spram_consts.svh"

module spram_bank (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cs,
    input  logic                      we,
    input  logic [`SPRAM_BANK_AW-1:0] addr,
    input  spram_pkg::half_t          wdata,
    input  spram_pkg::nib_mask_t      nib_mask,
    output spram_pkg::half_t          rdata
);

    localparam int DEPTH = 1 << `SPRAM_BANK_AW;

    spram_pkg::half_t mem [DEPTH]; // contents are not cleared

    // masked nibble write
    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int k = 0; k < 4; k++) begin
                if (nib_mask[k]) begin
                    mem[addr][4*k +: 4] <= wdata[4*k +: 4];
                end
            end
        end
    end

    // output register, holds on writes and deselected cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else if (cs && !we) begin
            rdata <= mem[addr];
        end
    end

    // a selected bank must see a clean address
    a_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        cs |-> !$isunknown(addr)
    ) else $error("spram_bank: unknown address while selected");

endmodule

`default_nettype wire

// ==== spram_req_decode.sv ====
// request decoder of the data memory
// word or byte request to row select, bank address, half data, nibble masks
// also hands the read selection to the read multiplexer
`timescale 1ns/1ns
`default_nettype none

`include "forth_spram_consts.svh"

module spram_req_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  spram_pkg::access_mode_e   mode,
    input  logic [`SPRAM_BYTE_AW-1:0] addr,
    input  spram_pkg::word_t          wdata,
    input  spram_pkg::lane_mask_t     bmsk,
    output logic [`SPRAM_NROWS-1:0]   row_sel,
    output logic [`SPRAM_BANK_AW-1:0] bank_addr,
    output spram_pkg::half_t          wdata_hi,
    output spram_pkg::half_t          wdata_lo,
    output spram_pkg::nib_mask_t      nib_mask_hi,
    output spram_pkg::nib_mask_t      nib_mask_lo,
    output logic                      bank_we,
    output logic                      rd,
    output logic                      rd_row,
    output logic [1:0]                rd_lane,
    output spram_pkg::access_mode_e   rd_mode
);

    logic [`SPRAM_WORD_AW-1:0] word_addr;
    logic [1:0]                lane;
    logic                      row;
    logic                      byte_acc;
    spram_pkg::lane_mask_t     lane_mask;
    spram_pkg::word_t          wdata_w;

    assign word_addr = addr[`SPRAM_BYTE_AW-1:2]; // same bits in both modes
    assign lane      = addr[1:0];
    assign row       = word_addr[`SPRAM_WORD_AW-1];
    assign byte_acc  = (mode == spram_pkg::acc_byte);

    always_comb begin
        row_sel      = '0;
        row_sel[row] = 1'b1;
    end

    assign bank_addr = word_addr[`SPRAM_BANK_AW-1:0];

    // byte mode writes only the addressed lane
    assign lane_mask = byte_acc ? spram_pkg::lane_mask_t'(4'b0001 << lane) : bmsk;
    assign wdata_w   = byte_acc ? {4{wdata[7:0]}} : wdata; // byte copied to every lane

    assign wdata_hi = wdata_w[31:16];
    assign wdata_lo = wdata_w[15:0];

    // each lane covers two nibbles
    assign nib_mask_hi = {lane_mask[3], lane_mask[3], lane_mask[2], lane_mask[2]};
    assign nib_mask_lo = {lane_mask[1], lane_mask[1], lane_mask[0], lane_mask[0]};

    assign bank_we = we;
    assign rd      = !we; // every non-write cycle is a read
    assign rd_row  = row;
    assign rd_lane = lane;
    assign rd_mode = mode;

    // an empty mask would make a word write a silent no-op
    a_word_mask: assert property (
        @(posedge clk) disable iff (reset)
        (we && !byte_acc) |-> (bmsk != '0)
    ) else $error("spram_req_decode: word write with empty byte mask");

endmodule

`default_nettype wire

// ==== spram_read_mux.sv ====
// read multiplexer of the data memory
// captures row, lane and mode of each read and drains the bank outputs
// word mode assembles both halves, byte mode zero-extends one lane
`timescale 1ns/1ns
`default_nettype none

`include "forth_spram_consts.svh"

module spram_read_mux (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rd,
    input  logic                    rd_row,
    input  logic [1:0]              rd_lane,
    input  spram_pkg::access_mode_e rd_mode,
    input  spram_pkg::half_t        bank_rdata [`SPRAM_NBANKS],
    output spram_pkg::word_t        rdata
);

    logic                    row_q;
    logic [1:0]              lane_q;
    spram_pkg::access_mode_e mode_q;
    spram_pkg::word_t        word_v;
    logic [7:0]              byte_v;

    // same edge that loads the bank output registers
    always_ff @(posedge clk) begin
        if (reset) begin
            row_q  <= 1'b0;
            lane_q <= '0;
            mode_q <= spram_pkg::acc_word;
        end else if (rd) begin
            row_q  <= rd_row;
            lane_q <= rd_lane;
            mode_q <= rd_mode;
        end
    end

    // even bank is the upper half of its row
    assign word_v = {bank_rdata[{row_q, 1'b0}], bank_rdata[{row_q, 1'b1}]};
    assign byte_v = word_v[8*lane_q +: 8];

    assign rdata = (mode_q == spram_pkg::acc_byte)
                 ? {{(`SPRAM_WORD_W-8){1'b0}}, byte_v}
                 : word_v;

    a_mode_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(mode_q)
    ) else $error("spram_read_mux: captured mode unknown");

endmodule

`default_nettype wire

// ==== forth_spram.sv ====
// top level of the 32K x 32 single-port data memory
// request decoder, four 16K x 16 banks and the read multiplexer
`timescale 1ns/1ns
`default_nettype none

`include "forth_spram_consts.svh"

module forth_spram (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  spram_pkg::access_mode_e   mode,
    input  logic [`SPRAM_BYTE_AW-1:0] addr,
    input  spram_pkg::word_t          wdata,
    input  spram_pkg::lane_mask_t     bmsk,
    output spram_pkg::word_t          rdata
);

    logic [`SPRAM_NROWS-1:0]   row_sel;
    logic [`SPRAM_BANK_AW-1:0] bank_addr;
    spram_pkg::half_t          wdata_hi;
    spram_pkg::half_t          wdata_lo;
    spram_pkg::nib_mask_t      nib_mask_hi;
    spram_pkg::nib_mask_t      nib_mask_lo;
    logic                      bank_we;
    logic                      rd;
    logic                      rd_row;
    logic [1:0]                rd_lane;
    spram_pkg::access_mode_e   rd_mode;
    spram_pkg::half_t          bank_rdata [`SPRAM_NBANKS];

    spram_req_decode u_decode (
        .clk, .reset, .we, .mode, .addr, .wdata, .bmsk,
        .row_sel, .bank_addr, .wdata_hi, .wdata_lo,
        .nib_mask_hi, .nib_mask_lo, .bank_we,
        .rd, .rd_row, .rd_lane, .rd_mode
    );

    // bank i sits in row i/2, even banks hold the upper half
    for (genvar i = 0; i < `SPRAM_NBANKS; i++) begin : g_bank
        spram_bank u_bank (
            .clk      (clk),
            .reset    (reset),
            .cs       (row_sel[i/2]),
            .we       (bank_we),
            .addr     (bank_addr),
            .wdata    ((i % 2 == 0) ? wdata_hi : wdata_lo),
            .nib_mask ((i % 2 == 0) ? nib_mask_hi : nib_mask_lo),
            .rdata    (bank_rdata[i])
        );
    end

    spram_read_mux u_rmux (
        .clk, .reset,
        .rd, .rd_row, .rd_lane, .rd_mode,
        .bank_rdata,
        .rdata
    );

endmodule

`default_nettype wire

// ==== forth_spram_tb.sv ====
// testbench of the 32K x 32 data memory
// stimulus table with expected read data from a word-addressed model
// directed word, mask, byte and hold cases, then an LCG random section
`timescale 1ns/1ns
`default_nettype none

`include "forth_spram_consts.svh"

module forth_spram_tb;

    localparam int RAND_N = 120;

    logic                      clk;
    logic                      reset;
    logic                      we;
    spram_pkg::access_mode_e   mode;
    logic [`SPRAM_BYTE_AW-1:0] addr;
    spram_pkg::word_t          wdata;
    spram_pkg::lane_mask_t     bmsk;
    spram_pkg::word_t          rdata;

    // stimulus table, one entry per clock
    string                     name_q  [$];
    logic                      we_q    [$];
    spram_pkg::access_mode_e   mode_q  [$];
    logic [`SPRAM_BYTE_AW-1:0] addr_q  [$];
    spram_pkg::word_t          wdata_q [$];
    spram_pkg::lane_mask_t     bmsk_q  [$];
    spram_pkg::word_t          exp_q   [$];
    logic                      chk_q   [$];

    spram_pkg::word_t model_mem [int]; // keyed by word address
    spram_pkg::word_t last_rd = '0;    // rdata holds this between reads
    int unsigned      lcg_state = 76;

    forth_spram UUT (.clk, .reset, .we, .mode, .addr, .wdata, .bmsk, .rdata);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // known content of words never written, mixes every address bit
    function automatic spram_pkg::word_t fill_word(input logic [`SPRAM_WORD_AW-1:0] wa);
        return ((32'(wa) + 32'd1) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    function automatic spram_pkg::word_t model_get(input logic [`SPRAM_WORD_AW-1:0] wa);
        if (model_mem.exists(int'(wa))) begin
            return model_mem[int'(wa)];
        end
        return fill_word(wa);
    endfunction

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]}; // weak low bits moved up
    endfunction

    task automatic check_eq(input string name, input spram_pkg::word_t expected,
                            input spram_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "read data mismatch");
        end
    endtask

    // appends one access and updates the model
    task automatic add_access(input string name, input logic w,
                              input spram_pkg::access_mode_e m,
                              input logic [`SPRAM_BYTE_AW-1:0] a, input spram_pkg::word_t d,
                              input spram_pkg::lane_mask_t msk, input logic chk);
        logic [`SPRAM_WORD_AW-1:0] wa;
        logic [1:0]                lane;
        spram_pkg::word_t          cur;
        wa   = a[`SPRAM_BYTE_AW-1:2];
        lane = a[1:0];
        cur  = model_get(wa);
        if (w) begin
            for (int b = 0; b < 4; b++) begin
                if (m == spram_pkg::acc_word && msk[b]) begin
                    cur[8*b +: 8] = d[8*b +: 8];
                end else if (m == spram_pkg::acc_byte && lane == b) begin
                    cur[8*b +: 8] = d[7:0]; // low byte of wdata
                end
            end
            model_mem[int'(wa)] = cur;
        end else if (m == spram_pkg::acc_word) begin
            last_rd = cur;
        end else begin
            last_rd = {24'h0, cur[8*lane +: 8]};
        end
        name_q.push_back(name);
        we_q.push_back(w);
        mode_q.push_back(m);
        addr_q.push_back(a);
        wdata_q.push_back(d);
        bmsk_q.push_back(msk);
        exp_q.push_back(last_rd);
        chk_q.push_back(chk);
    endtask

    task automatic write_word(input string name, input logic [`SPRAM_WORD_AW-1:0] wa,
                              input spram_pkg::word_t d, input spram_pkg::lane_mask_t msk,
                              input logic chk);
        add_access(name, 1'b1, spram_pkg::acc_word, {wa, 2'b00}, d, msk, chk);
    endtask

    task automatic read_word(input string name, input logic [`SPRAM_WORD_AW-1:0] wa);
        add_access(name, 1'b0, spram_pkg::acc_word, {wa, 2'b00}, '0, 4'hF, 1'b1);
    endtask

    task automatic write_byte(input string name, input logic [`SPRAM_WORD_AW-1:0] wa,
                              input logic [1:0] lane, input logic [7:0] b, input logic chk);
        add_access(name, 1'b1, spram_pkg::acc_byte, {wa, lane}, {24'hA5A5A5, b}, 4'h0, chk);
    endtask

    task automatic read_byte(input string name, input logic [`SPRAM_WORD_AW-1:0] wa,
                             input logic [1:0] lane);
        add_access(name, 1'b0, spram_pkg::acc_byte, {wa, lane}, '0, 4'h0, 1'b1);
    endtask

    task automatic build_table();
        logic [`SPRAM_WORD_AW-1:0] pool [8];
        logic [`SPRAM_WORD_AW-1:0] wa;
        int unsigned               r;
        spram_pkg::lane_mask_t     msk;
        pool = '{15'h0003, 15'h0004, 15'h1FFF, 15'h3FFF, 15'h4000, 15'h4003, 15'h5A5A, 15'h7FFF};
        // same bank address in both rows, ends of the bank range
        write_word("word_r0", 15'h0010, 32'h0123_4567, 4'hF, 1'b0);
        write_word("word_r1", 15'h4010, 32'h89AB_CDEF, 4'hF, 1'b0);
        write_word("word_r0_end", 15'h3FFF, 32'hCAFE_F00D, 4'hF, 1'b0);
        write_word("word_r1_end", 15'h7FFF, 32'h1357_9BDF, 4'hF, 1'b0);
        write_word("word_zero", 15'h0000, 32'hFFFF_0001, 4'hF, 1'b0);
        read_word("rd_r0", 15'h0010);
        read_word("rd_r1", 15'h4010);
        read_word("rd_r0_end", 15'h3FFF);
        read_word("rd_r1_end", 15'h7FFF);
        read_word("rd_zero", 15'h0000);
        // partial byte masks
        write_word("part_base", 15'h0123, 32'h1122_3344, 4'hF, 1'b0);
        write_word("part_0101", 15'h0123, 32'hAABB_CCDD, 4'b0101, 1'b0);
        read_word("rd_part_0101", 15'h0123);
        write_word("part_1000", 15'h0123, 32'hEE00_0000, 4'b1000, 1'b0);
        read_word("rd_part_1000", 15'h0123);
        // byte lanes one at a time
        write_word("byte_base", 15'h4567, 32'hDEAD_BEEF, 4'hF, 1'b0);
        for (int l = 0; l < 4; l++) begin
            write_byte($sformatf("byte_wr_l%0d", l), 15'h4567, 2'(l), 8'(8'h12 + 8'h22 * l), 1'b0);
            read_byte($sformatf("byte_rd_l%0d", l), 15'h4567, 2'(l));
            read_word($sformatf("byte_word_l%0d", l), 15'h4567);
        end
        // rdata must not move on writes
        read_word("hold_rd", 15'h0010);
        write_word("hold_same", 15'h0010, 32'h0F0F_0F0F, 4'hF, 1'b1);
        write_byte("hold_byte", 15'h0010, 2'd2, 8'h99, 1'b1);
        write_word("hold_other", 15'h4010, 32'h7777_7777, 4'b0011, 1'b1);
        read_word("hold_new", 15'h0010);
        // random section on a small pool, filled first
        foreach (pool[p]) begin
            write_word($sformatf("fill_%0d", p), pool[p], fill_word(pool[p]), 4'hF, 1'b0);
        end
        for (int n = 0; n < RAND_N; n++) begin
            r   = lcg_next();
            wa  = pool[r[2:0]];
            msk = r[10:7];
            if (msk == '0) begin
                msk = 4'hF; // word writes never get an empty mask
            end
            add_access($sformatf("rand_%0d", n), r[3], spram_pkg::access_mode_e'(r[4]),
                       {wa, r[6:5]}, lcg_next(), msk, !r[3]);
        end
    endtask

    task automatic wait_reset_release(input int limit);
        int n;
        n = 0;
        while (reset && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (reset) begin
            $display("reset still high after %0d clock cycles", limit);
            $display("STATUS: FAIL");
            $fatal(1, "reset release timed out");
        end
    endtask

    task automatic drive_entry(input int i);
        we    <= we_q[i];
        mode  <= mode_q[i];
        addr  <= addr_q[i];
        wdata <= wdata_q[i];
        bmsk  <= bmsk_q[i];
    endtask

    // idle cycles rewrite the fill of word 0, rdata untouched
    task automatic drive_idle();
        we    <= 1'b1;
        mode  <= spram_pkg::acc_word;
        addr  <= '0;
        wdata <= fill_word('0);
        bmsk  <= 4'hF;
    endtask

    initial begin
        int last;
        reset = 1'b1;
        we    = 1'b1;
        mode  = spram_pkg::acc_word;
        addr  = '0;
        wdata = fill_word('0);
        bmsk  = 4'hF;
        build_table();
        last = name_q.size() - 1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait_reset_release(10);
        @(negedge clk);
        check_eq("after_reset", '0, rdata);
        for (int i = 0; i <= last; i++) begin
            @(posedge clk);
            drive_entry(i);
            @(negedge clk);
            if (i > 0 && chk_q[i-1]) begin
                check_eq(name_q[i-1], exp_q[i-1], rdata); // sampled at this edge
            end
        end
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        if (chk_q[last]) begin
            check_eq(name_q[last], exp_q[last], rdata);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== forth_spram.f ====
+incdir+.
spram_pkg.sv
spram_bank.sv
spram_req_decode.sv
spram_read_mux.sv
forth_spram.sv
forth_spram_tb.sv

// ==== Bender.yml ====
package:
  name: forth_spram

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - spram_pkg.sv
      - spram_bank.sv
      - spram_req_decode.sv
      - spram_read_mux.sv
      - forth_spram.sv

  - target: test
    include_dirs:
      - .
    files:
      - forth_spram_tb.sv
